// File: hdl/stream_pkg.sv
// Transport formats only: 32-bit words with a last flag, no tkeep, tid or tdest, no zero-word packets.

package stream_pkg;

    // **********************************************************************
    // widths
    // **********************************************************************

    localparam int DATA_WIDTH = 32;  // payload word width in bits.

    // **********************************************************************
    // word formats
    // **********************************************************************

    // input word as it arrives from the upstream source.
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;  // payload data, passed through unchanged.
        logic                  last;  // set on the final word of a packet.
    } stream_word_t;

    // output word; last moves from the final payload word to the trailer.
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;     // payload data or the trailer value.
        logic                  last;     // set only on the trailer word.
        logic                  trailer;  // marks the appended trailer word.
    } stream_out_t;

endpackage

// File: hdl/trailer_pkg.sv
// Trailer layout is fixed at 16-bit count over 16-bit sum, both wrapping mod 65536 with no overflow flag.

package trailer_pkg;

    // **********************************************************************
    // accumulator widths
    // **********************************************************************

    localparam int COUNT_WIDTH = 16;  // word count width, wraps silently.
    localparam int SUM_WIDTH   = 16;  // halfword sum width, wraps silently.

    // **********************************************************************
    // trailer word layout
    // **********************************************************************

    // count sits in the upper half so a 32-bit trailer word reads count:sum.
    typedef struct packed {
        logic [COUNT_WIDTH-1:0] count;  // number of payload words in the packet.
        logic [SUM_WIDTH-1:0]   sum;    // sum of both halves of every payload word.
    } trailer_t;

    // **********************************************************************
    // control states
    // **********************************************************************

    typedef enum logic [0:0] {
        PASS    = 1'b0,  // payload words flow through.
        TRAILER = 1'b1   // input stalled while the trailer word goes out.
    } ctrl_state_t;

endpackage

// File: hdl/stream_buffered.sv
// One-entry skid buffer; rx_ready lags tx_ready by a cycle and is low out of reset.
`timescale 1ns/1ns

module stream_buffered #(
    parameter type payload_t = logic  // payload carried alongside valid and ready.
) (
    input  logic     aclk,        // clock.
    input  logic     areset_n,    // asynchronous reset, active low.
    input  logic     rx_valid,    // upstream word valid.
    output logic     rx_ready,    // registered copy of tx_ready.
    input  payload_t rx_payload,  // upstream word.
    output logic     tx_valid,    // downstream word valid.
    input  logic     tx_ready,    // downstream ready.
    output payload_t tx_payload   // downstream word.
);

    // **********************************************************************
    // state and storage
    // **********************************************************************

    typedef enum logic [0:0] {
        IDLE     = 1'b0,  // words pass straight from rx to tx.
        BUFFERED = 1'b1   // the skid entry holds a word for tx.
    } buf_state_t;

    buf_state_t state;     // current buffer state.
    payload_t   skid_q;    // word caught while tx_ready was low.
    logic       rx_fire;   // a word is accepted from upstream.

    assign rx_fire = rx_valid && rx_ready;  // handshake on the rx side.

    // the skid entry fills when an accepted word cannot leave at once.
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            state <= IDLE;  // start with an empty skid entry.
        end else begin
            case (state)
                IDLE: begin
                    if (rx_fire && !tx_ready) begin
                        state <= BUFFERED;  // word in flight must be held.
                    end
                end
                BUFFERED: begin
                    if (tx_ready) begin
                        state <= IDLE;  // held word leaves this cycle.
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // breaking the ready path here is the whole point of this block.
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            rx_ready <= 1'b0;  // refuse words until downstream is seen ready.
        end else begin
            rx_ready <= tx_ready;  // one cycle late, covered by the skid entry.
        end
    end

    always_ff @(posedge aclk) begin
        if (rx_fire) begin
            skid_q <= rx_payload;  // only used if the state moves to BUFFERED.
        end
    end

    // **********************************************************************
    // output select
    // **********************************************************************

    always_comb begin
        if (state == BUFFERED) begin
            tx_valid   = 1'b1;    // held word is always on offer.
            tx_payload = skid_q;  // present the stored copy.
        end else begin
            tx_valid   = rx_fire;     // zero-latency pass in idle.
            tx_payload = rx_payload;  // word goes straight through.
        end
    end

    // a held word must not drop or change while downstream stalls.
    hold_stable: assert property (@(posedge aclk) disable iff (!areset_n)
        (state == BUFFERED && !tx_ready) |=> (tx_valid && $stable(tx_payload)));

endmodule

// File: hdl/packet_accumulator.sv
// Count and sum wrap mod 65536 without warning; add and clear must never be raised together.
`timescale 1ns/1ns

module packet_accumulator (
    input  logic                             aclk,      // clock.
    input  logic                             areset_n,  // asynchronous reset, active low.
    input  logic                             add,       // a payload word transfers this cycle.
    input  logic                             clear,     // the trailer transfers this cycle.
    input  logic [stream_pkg::DATA_WIDTH-1:0] word,      // data of the word being added.
    output trailer_pkg::trailer_t            trailer    // totals including this cycle's add.
);

    localparam int HALF = stream_pkg::DATA_WIDTH / 2;  // width of one halfword.

    logic [trailer_pkg::COUNT_WIDTH-1:0] count_q;    // words added so far.
    logic [trailer_pkg::SUM_WIDTH-1:0]   sum_q;      // halfword sum so far.
    logic [trailer_pkg::COUNT_WIDTH-1:0] count_nxt;  // count after this cycle's add.
    logic [trailer_pkg::SUM_WIDTH-1:0]   sum_nxt;    // sum after this cycle's add.

    // **********************************************************************
    // next totals
    // **********************************************************************

    always_comb begin
        count_nxt = count_q;  // hold unless a word arrives.
        sum_nxt   = sum_q;
        if (add) begin
            count_nxt = count_q + 1'b1;  // truncation gives the mod 65536 wrap.
            sum_nxt   = sum_q + word[stream_pkg::DATA_WIDTH-1:HALF] + word[HALF-1:0];
        end
    end

    // the control block samples the trailer in the cycle of the last add.
    assign trailer.count = count_nxt;
    assign trailer.sum   = sum_nxt;

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            count_q <= '0;  // no packet in progress.
            sum_q   <= '0;
        end else if (clear) begin
            count_q <= '0;  // ready for the next packet.
            sum_q   <= '0;
        end else begin
            count_q <= count_nxt;
            sum_q   <= sum_nxt;
        end
    end

    // the trailer cycle stalls the input, so the two strobes are exclusive.
    no_add_on_clear: assert property (@(posedge aclk) disable iff (!areset_n)
        !(add && clear));

endmodule

// File: hdl/trailer_ctrl.sv
// Assumes every packet ends with last and has at least one word; adds one trailer cycle per packet.
`timescale 1ns/1ns

module trailer_ctrl (
    input  logic                              aclk,         // clock.
    input  logic                              areset_n,     // asynchronous reset, active low.
    input  logic                              in_valid,     // input word valid.
    output logic                              in_ready,     // input ready, low in TRAILER.
    input  stream_pkg::stream_word_t          in_word,      // input word.
    output logic                              out_valid,    // output word valid.
    input  logic                              out_ready,    // output ready.
    output stream_pkg::stream_out_t           out_word,     // output word.
    output logic                              acc_add,      // add in_word to the totals.
    output logic                              acc_clear,    // reset the totals.
    output logic [stream_pkg::DATA_WIDTH-1:0] acc_word,     // data handed to the totals.
    input  trailer_pkg::trailer_t             acc_trailer   // totals including this add.
);

    trailer_pkg::ctrl_state_t state;      // current control state.
    trailer_pkg::ctrl_state_t state_nxt;  // state for the next cycle.
    trailer_pkg::trailer_t    trailer_q;  // trailer value frozen at packet end.
    logic                     in_fire;    // a payload word transfers in.
    logic                     out_fire;   // an output word transfers out.

    assign in_fire  = in_valid && in_ready;    // input handshake.
    assign out_fire = out_valid && out_ready;  // output handshake.

    // **********************************************************************
    // datapath and handshakes
    // **********************************************************************

    always_comb begin
        case (state)
            trailer_pkg::TRAILER: begin
                in_ready         = 1'b0;       // stall upstream for one slot.
                out_valid        = 1'b1;       // trailer is always ready to go.
                out_word.data    = trailer_q;  // count over sum.
                out_word.last    = 1'b1;       // the trailer closes the packet.
                out_word.trailer = 1'b1;
            end
            default: begin
                in_ready         = out_ready;     // ready passes straight through.
                out_valid        = in_valid;
                out_word.data    = in_word.data;  // payload is unchanged.
                out_word.last    = 1'b0;          // last moves to the trailer.
                out_word.trailer = 1'b0;
            end
        endcase
    end

    // in_ready is only high in PASS, so in_fire already implies a payload word.
    assign acc_add   = in_fire;
    assign acc_word  = in_word.data;
    assign acc_clear = (state == trailer_pkg::TRAILER) && out_fire;

    // **********************************************************************
    // state machine
    // **********************************************************************

    always_comb begin
        state_nxt = state;  // stay put by default.
        case (state)
            trailer_pkg::PASS: begin
                if (in_fire && in_word.last) begin
                    state_nxt = trailer_pkg::TRAILER;  // packet complete.
                end
            end
            trailer_pkg::TRAILER: begin
                if (out_fire) begin
                    state_nxt = trailer_pkg::PASS;  // trailer delivered.
                end
            end
            default: state_nxt = trailer_pkg::PASS;
        endcase
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            state <= trailer_pkg::PASS;  // idle between packets.
        end else begin
            state <= state_nxt;
        end
    end

    // acc_trailer already counts the last word in the cycle it is added.
    always_ff @(posedge aclk) begin
        if (in_fire && in_word.last) begin
            trailer_q <= acc_trailer;
        end
    end

    // the input is stalled in TRAILER, so the accumulator totals still match the frozen trailer.
    trailer_matches_totals: assert property (@(posedge aclk) disable iff (!areset_n)
        (state == trailer_pkg::TRAILER) |-> (!in_ready && acc_trailer == trailer_q));

endmodule

// File: hdl/packet_trailer_top.sv
// Latency depends on back-pressure; in_ready rises two cycles after reset release with out_ready high.
`timescale 1ns/1ns

module packet_trailer_top (
    input  logic                     aclk,       // clock.
    input  logic                     areset_n,   // asynchronous reset, active low.
    input  logic                     in_valid,   // input word valid.
    output logic                     in_ready,   // input ready, registered.
    input  stream_pkg::stream_word_t in_word,    // input word.
    output logic                     out_valid,  // output word valid.
    input  logic                     out_ready,  // output ready.
    output stream_pkg::stream_out_t  out_word    // output word.
);

    // **********************************************************************
    // internal streams
    // **********************************************************************

    logic                                buf_valid;    // input buffer to control.
    logic                                buf_ready;
    stream_pkg::stream_word_t            buf_word;
    logic                                ctrl_valid;   // control to output buffer.
    logic                                ctrl_ready;
    stream_pkg::stream_out_t             ctrl_word;
    logic                                acc_add;      // accumulator strobes.
    logic                                acc_clear;
    logic [stream_pkg::DATA_WIDTH-1:0]   acc_word;
    trailer_pkg::trailer_t               acc_trailer;  // running totals.

    stream_buffered #(.payload_t(stream_pkg::stream_word_t)) u_in_buf (
        .aclk       (aclk),
        .areset_n   (areset_n),
        .rx_valid   (in_valid),
        .rx_ready   (in_ready),
        .rx_payload (in_word),
        .tx_valid   (buf_valid),
        .tx_ready   (buf_ready),
        .tx_payload (buf_word)
    );

    trailer_ctrl u_ctrl (
        .aclk        (aclk),
        .areset_n    (areset_n),
        .in_valid    (buf_valid),
        .in_ready    (buf_ready),
        .in_word     (buf_word),
        .out_valid   (ctrl_valid),
        .out_ready   (ctrl_ready),
        .out_word    (ctrl_word),
        .acc_add     (acc_add),
        .acc_clear   (acc_clear),
        .acc_word    (acc_word),
        .acc_trailer (acc_trailer)
    );

    packet_accumulator u_acc (
        .aclk     (aclk),
        .areset_n (areset_n),
        .add      (acc_add),
        .clear    (acc_clear),
        .word     (acc_word),
        .trailer  (acc_trailer)
    );

    // the output buffer keeps out_ready off the control block's ready path.
    stream_buffered #(.payload_t(stream_pkg::stream_out_t)) u_out_buf (
        .aclk       (aclk),
        .areset_n   (areset_n),
        .rx_valid   (ctrl_valid),
        .rx_ready   (ctrl_ready),
        .rx_payload (ctrl_word),
        .tx_valid   (out_valid),
        .tx_ready   (out_ready),
        .tx_payload (out_word)
    );

endmodule

// File: testbench/tb_reference.svh
// Trailer reference model and expected-word queue; included inside the testbench module only.
`ifndef TB_REFERENCE_SVH
`define TB_REFERENCE_SVH

// **********************************************************************
// scoreboard state
// **********************************************************************

stream_pkg::stream_out_t expected_q[$];  // words the DUT must produce, in order.
int                      error_count = 0;  // failed checks over the whole run.
int                      check_count = 0;  // checks made over the whole run.

// trailer rule: count of words over the sum of both halves of every word, both mod 65536.
function automatic logic [31:0] reference_trailer(input logic [31:0] words[$]);
    logic [15:0] count;  // word count, truncated to 16 bits.
    logic [15:0] sum;    // halfword sum, wraps by its width.
    count = 16'(words.size());
    sum   = 16'h0000;
    foreach (words[i]) begin
        sum = sum + words[i][31:16];  // upper halfword.
        sum = sum + words[i][15:0];   // lower halfword.
    end
    return {count, sum};
endfunction

// payload words come out unchanged with last cleared, then one trailer closes the packet.
task automatic queue_packet(input logic [31:0] words[$]);
    stream_pkg::stream_out_t exp_word;  // expected output word.
    foreach (words[i]) begin
        exp_word.data    = words[i];
        exp_word.last    = 1'b0;  // last moves to the trailer.
        exp_word.trailer = 1'b0;
        expected_q.push_back(exp_word);
    end
    exp_word.data    = reference_trailer(words);
    exp_word.last    = 1'b1;  // only the trailer carries last.
    exp_word.trailer = 1'b1;
    expected_q.push_back(exp_word);
endtask

task automatic check_value(input string name, input string field,
                           input logic [31:0] expected, input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
        $display("MISMATCH test %s %s expected 0x%08h actual 0x%08h",
                 name, field, expected, actual);
        error_count++;
    end
endtask

`endif

// File: testbench/tb_packet_trailer.sv
// Fixed seed 18403; inputs change on the falling edge, outputs are sampled on the rising edge.
`timescale 1ns/1ns

module tb_packet_trailer;

    // **********************************************************************
    // test sizes and run limit
    // **********************************************************************

    localparam int MULTI_PKTS    = 10;  // packets in the multi-word test.
    localparam int MULTI_MAX_LEN = 8;   // longest multi-word packet.
    localparam int RAND_PKTS     = 40;  // packets in the random test.
    localparam int RAND_MAX_LEN  = 20;  // longest random packet.
    localparam int RAND_MAX_GAP  = 3;   // longest idle gap between input words.
    localparam int WRAP_PKTS     = 3;   // packets of all-ones words.
    localparam int WRAP_MAX_LEN  = 32;  // longest all-ones packet, lengths 2, 17, 32.
    // every packet adds a trailer word, so each length counts one extra.
    localparam int MAX_WORDS     = 2 + MULTI_PKTS * (MULTI_MAX_LEN + 1)
                                 + RAND_PKTS * (RAND_MAX_LEN + 1)
                                 + WRAP_PKTS * (WRAP_MAX_LEN + 1);
    localparam int CYCLE_LIMIT   = 4 * MAX_WORDS + 200;  // cycles before the run is stopped.

    logic                     aclk = 1'b0;       // 40 ns clock.
    logic                     areset_n;          // DUT reset, active low.
    logic                     in_valid;          // input stream.
    logic                     in_ready;
    stream_pkg::stream_word_t in_word;
    logic                     out_valid;         // output stream.
    logic                     out_ready = 1'b1;  // high unless back-pressure is on.
    stream_pkg::stream_out_t  out_word;

    string test_name        = "reset_idle";  // name shown in error and test lines.
    logic  idle_check       = 1'b0;          // expect no output while set.
    logic  backpressure     = 1'b0;          // random out_ready low periods while set.
    int    cycle_count      = 0;             // rising edges seen so far.
    int    tests_done       = 0;             // tests that have finished.
    int    checks_at_start  = 0;             // check count when the test began.
    int    errors_at_start  = 0;             // error count when the test began.

    `include "tb_reference.svh"

    always #20 aclk = ~aclk;  // period 40 ns.

    packet_trailer_top uut (
        .aclk      (aclk),
        .areset_n  (areset_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_word   (in_word),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_word  (out_word)
    );

    // **********************************************************************
    // output side
    // **********************************************************************

    // the sink stalls about one cycle in four when back-pressure is on.
    always @(negedge aclk) begin
        if (backpressure) begin
            out_ready <= ($urandom % 4) != 0;
        end else begin
            out_ready <= 1'b1;
        end
    end

    // flops have not yet updated here, so every signal still holds its pre-edge value.
    always @(posedge aclk) begin
        stream_pkg::stream_out_t exp_word;  // word popped from the expected queue.
        if (idle_check) begin
            check_value(test_name, "out_valid", 32'd0, 32'(out_valid));
            if (!areset_n) begin
                check_value(test_name, "in_ready", 32'd0, 32'(in_ready));  // held in reset.
            end
        end
        if (areset_n && out_valid && out_ready) begin
            if (expected_q.size() == 0) begin
                $display("ERROR: test %s produced output word 0x%08h when none was expected",
                         test_name, out_word.data);
                error_count++;
            end else begin
                exp_word = expected_q.pop_front();
                check_value(test_name, "data", exp_word.data, out_word.data);
                check_value(test_name, "last", 32'(exp_word.last), 32'(out_word.last));
                check_value(test_name, "trailer", 32'(exp_word.trailer), 32'(out_word.trailer));
            end
        end
    end

    // the run stops here if the tests have not ended by the limit.
    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge aclk);
            cycle_count++;
        end
        $display("ERROR: timeout in test %s, the run did not end within %0d cycles",
                 test_name, CYCLE_LIMIT);
        $display("Result: FAILED");
        $finish;
    end

    // **********************************************************************
    // stimulus
    // **********************************************************************

    // called on a falling edge; returns on the falling edge after the transfer.
    task automatic send_word(input logic [31:0] data, input logic last);
        in_valid     = 1'b1;
        in_word.data = data;
        in_word.last = last;
        while (!in_ready) begin
            @(negedge aclk);  // in_ready is registered, so it is stable here.
        end
        @(negedge aclk);  // the word transfers on the rising edge in between.
        in_valid = 1'b0;
    endtask

    task automatic send_packet(input logic [31:0] words[$], input int max_gap);
        int gap;  // idle cycles after the current word.
        queue_packet(words);  // expected words go in before any can come out.
        foreach (words[i]) begin
            send_word(words[i], i == words.size() - 1);
            gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
            repeat (gap) @(negedge aclk);
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        checks_at_start = check_count;
        errors_at_start = error_count;
    endtask

    // a test is over once every expected word has been seen at the output.
    task automatic end_test();
        while (expected_q.size() != 0) begin
            @(negedge aclk);
        end
        repeat (4) @(negedge aclk);  // room for any extra word to show up.
        tests_done++;
        $display("test %s finished: %0d checks, %0d errors", test_name,
                 check_count - checks_at_start, error_count - errors_at_start);
    endtask

    task automatic run_packets(input string name, input int pkts, input int min_len,
                               input int max_len, input int max_gap);
        logic [31:0] words[$];  // payload of the packet being built.
        int          len;       // words in the packet.
        int          p;         // packet index.
        int          i;         // word index.
        start_test(name);
        for (p = 0; p < pkts; p++) begin
            words.delete();
            len = int'($urandom_range(max_len, min_len));
            for (i = 0; i < len; i++) begin
                words.push_back($urandom);
            end
            send_packet(words, max_gap);
        end
        end_test();
    endtask

    task automatic run_wrap();
        logic [31:0] words[$];  // all-ones payload.
        int          p;         // packet index.
        int          i;         // word index.
        start_test("sum_wrap");
        for (p = 0; p < WRAP_PKTS; p++) begin
            words.delete();
            for (i = 0; i < 2 + 15 * p; i++) begin
                words.push_back(32'hffff_ffff);  // each word adds 0x1fffe to the sum.
            end
            send_packet(words, 0);
        end
        end_test();
    endtask

    initial begin
        logic [31:0] single[$];  // one-word packet.
        void'($urandom(18403));
        areset_n     = 1'b0;
        in_valid     = 1'b0;
        in_word      = '0;
        idle_check   = 1'b1;  // reset and idle period are watched by the monitor.
        start_test("reset_idle");
        repeat (8) @(negedge aclk);
        areset_n = 1'b1;
        repeat (10) @(negedge aclk);  // no input offered, so nothing may come out.
        idle_check = 1'b0;
        end_test();

        start_test("single_word");
        single.push_back(32'h1234_abcd);  // trailer 0x0001be01.
        send_packet(single, 0);
        end_test();

        run_packets("multi_word", MULTI_PKTS, 2, MULTI_MAX_LEN, 0);

        backpressure = 1'b1;
        run_packets("random_stall", RAND_PKTS, 1, RAND_MAX_LEN, RAND_MAX_GAP);
        backpressure = 1'b0;

        run_wrap();

        $display("tests %0d, checks %0d, errors %0d", tests_done, check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+testbench
hdl/stream_pkg.sv
hdl/trailer_pkg.sv
hdl/stream_buffered.sv
hdl/packet_accumulator.sv
hdl/trailer_ctrl.sv
hdl/packet_trailer_top.sv
testbench/tb_packet_trailer.sv

// File: Makefile
# Verilator build and run of the packet trailer testbench.
# Every variable below can be overridden on the command line, e.g. make test BUILD_DIR=build.

VERILATOR ?= verilator
TOP       ?= tb_packet_trailer
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Result: PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST)) testbench/tb_reference.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator, run it and check the result"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the output is kept in a shell variable and searched for the pass line.
test: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_TEXT)"; then \
		echo "make test: simulation passed"; \
	else \
		echo "make test: simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
